// ==== intra16_macros.svh ====
`ifndef INTRA16_MACROS_SVH
`define INTRA16_MACROS_SVH

`define SAMPLE_W 8
`define WORD_W 32
`define EDGE_LEN 16

// Plane terms need about 15 bits plus sign
`define PLANE_W 16

`define DC_DEFAULT 128
`define DC_RND_ONE 8     // One edge of 16 samples
`define DC_RND_BOTH 16   // Both edges, 32 samples

`define PARAM_RND 32     // For (5*H + 32) >> 6
`define PLANE_RND 16     // For the final >> 5

`endif

// ==== intra16_pkg.sv ====
`include "intra16_macros.svh"

package intra16_pkg;

	typedef enum logic [1:0] {
		mode_vertical,
		mode_horizontal,
		mode_dc,
		mode_plane
	} pred_mode_e;

	typedef enum logic [2:0] {
		op_none,
		op_top,      // Four consecutive words
		op_left0,
		op_left1,
		op_left2,
		op_left3,
		op_corner
	} edge_op_e;

	typedef struct packed {
		logic [`EDGE_LEN-1:0][`SAMPLE_W-1:0] top;
		logic [`EDGE_LEN-1:0][`SAMPLE_W-1:0] left;
		logic [`SAMPLE_W-1:0] corner;   // Above-left
	} edge_set_t;

	// Two's complement values
	typedef struct packed {
		logic [`PLANE_W-1:0] a;
		logic [`PLANE_W-1:0] b;
		logic [`PLANE_W-1:0] c;
	} plane_param_t;

	typedef struct packed {
		logic [`EDGE_LEN-1:0][`SAMPLE_W-1:0] px;   // Sample (x, y) sits at index 4*y+x
	} pred_block_t;

endpackage

// ==== intra16_edge_store.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module intra16_edge_store (
	input  logic                   clk,
	input  logic                   reset_n,
	input  intra16_pkg::edge_op_e  edge_op,
	input  logic [`WORD_W-1:0]     edge_word,
	output intra16_pkg::edge_set_t edges
);

	localparam int SW = `SAMPLE_W;
	localparam int WORD_SAMPLES = `WORD_W / `SAMPLE_W;

	logic [1:0] top_word;       // Which top word arrives next
	logic [1:0] left_quarter;

	assign left_quarter = 2'(edge_op - intra16_pkg::op_left0);   // Only meaningful for op_leftN

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			top_word <= '0;
			edges <= '0;
		end else begin
			if (edge_op == intra16_pkg::op_top) begin
				top_word <= top_word + 2'd1;
			end else begin
				top_word <= '0;
			end

			case (edge_op)
				intra16_pkg::op_top: begin
					for (int k = 0; k < WORD_SAMPLES; k++) begin
						edges.top[{top_word, 2'(k)}] <= edge_word[SW*k +: SW];
					end
				end
				intra16_pkg::op_left0,
				intra16_pkg::op_left1,
				intra16_pkg::op_left2,
				intra16_pkg::op_left3: begin
					for (int k = 0; k < WORD_SAMPLES; k++) begin
						edges.left[{left_quarter, 2'(k)}] <= edge_word[SW*k +: SW];
					end
				end
				intra16_pkg::op_corner: begin
					edges.corner <= edge_word[SW-1:0];   // Lowest byte only
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== intra16_plane_param.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module intra16_plane_param (
	input  logic                      clk,
	input  logic                      reset_n,
	input  intra16_pkg::edge_set_t    edges,
	input  logic                      param_strobe,
	output intra16_pkg::plane_param_t params
);

	localparam int SW = `SAMPLE_W;
	localparam int PW = `PLANE_W;
	localparam int HALF = `EDGE_LEN / 2;

	logic signed [PW-1:0] grad_h;
	logic signed [PW-1:0] grad_v;
	logic signed [PW-1:0] a_val;

	// Corner takes the place of sample -1 in the weighted sum
	function automatic logic signed [PW-1:0] gradient(
		input logic [`EDGE_LEN-1:0][SW-1:0] line,
		input logic [SW-1:0] corner
	);
		logic [`EDGE_LEN:0][SW-1:0] ext;
		logic signed [PW-1:0] far_s;
		logic signed [PW-1:0] near_s;
		logic signed [PW-1:0] acc;
		ext = {line, corner};
		acc = '0;
		for (int x = 0; x < HALF; x++) begin
			far_s = PW'(ext[HALF + 1 + x]);
			near_s = PW'(ext[HALF - 1 - x]);
			acc = acc + PW'((x + 1) * (far_s - near_s));
		end
		return acc;
	endfunction

	function automatic logic signed [PW-1:0] slope(input logic signed [PW-1:0] g);
		logic signed [PW+3:0] t;
		t = (PW+4)'(g);
		t = (t <<< 2) + t + (PW+4)'(`PARAM_RND);   // 5*g + 32 can pass 16 bits
		return PW'(t >>> 6);
	endfunction

	assign grad_h = gradient(edges.top, edges.corner);
	assign grad_v = gradient(edges.left, edges.corner);
	assign a_val = (PW'(edges.left[`EDGE_LEN-1]) + PW'(edges.top[`EDGE_LEN-1])) <<< 4;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			params <= '0;
		end else if (param_strobe) begin
			params.a <= a_val;
			params.b <= slope(grad_h);
			params.c <= slope(grad_v);
		end
	end

endmodule

// ==== intra16_plane_block.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module intra16_plane_block (
	input  logic                      clk,
	input  logic                      reset_n,
	input  intra16_pkg::plane_param_t params,
	input  logic [3:0]                block_idx,
	input  logic                      plane_strobe,
	output intra16_pkg::pred_block_t  plane_blk
);

	localparam int SW = `SAMPLE_W;
	localparam int PW = `PLANE_W;
	localparam int CENTRE = `EDGE_LEN / 2 - 1;
	localparam int MAX_PIX = (1 << `SAMPLE_W) - 1;

	logic signed [PW-1:0] a_s;
	logic signed [PW-1:0] b_s;
	logic signed [PW-1:0] c_s;
	logic signed [PW-1:0] b_mul [`EDGE_LEN];   // b times (x-7) for every column
	logic signed [PW-1:0] c_mul [`EDGE_LEN];
	logic [3:0] col0;
	logic [3:0] row0;
	intra16_pkg::pred_block_t blk_next;

	// Multiples -7 to +8 built from shifts and adds
	function automatic logic signed [PW-1:0] times_offset(
		input logic signed [PW-1:0] v,
		input int pos
	);
		logic signed [PW-1:0] acc;
		int mag;
		acc = '0;
		mag = (pos < CENTRE) ? CENTRE - pos : pos - CENTRE;
		for (int s = 0; s < 4; s++) begin
			if (mag[s]) begin
				acc = acc + (v <<< s);
			end
		end
		return (pos < CENTRE) ? -acc : acc;
	endfunction

	function automatic logic [SW-1:0] clip(input logic signed [PW-1:0] s);
		logic signed [PW-1:0] v;
		v = s >>> 5;
		if (v < 0) begin
			clip = '0;
		end else if (v > MAX_PIX) begin
			clip = '1;
		end else begin
			clip = v[SW-1:0];
		end
	endfunction

	assign a_s = $signed(params.a);
	assign b_s = $signed(params.b);
	assign c_s = $signed(params.c);
	assign col0 = {block_idx[1:0], 2'b00};
	assign row0 = {block_idx[3:2], 2'b00};

	always_comb begin
		for (int i = 0; i < `EDGE_LEN; i++) begin
			b_mul[i] = times_offset(b_s, i);
			c_mul[i] = times_offset(c_s, i);
		end
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				blk_next.px[4*y + x] = clip(a_s + b_mul[col0 + 4'(x)] + c_mul[row0 + 4'(y)]
					+ PW'(`PLANE_RND));
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			plane_blk <= '0;
		end else if (plane_strobe) begin
			plane_blk <= blk_next;   // Holds until the output stage takes it
		end
	end

endmodule

// ==== intra16_block_out.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module intra16_block_out (
	input  logic                     clk,
	input  logic                     reset_n,
	input  intra16_pkg::edge_set_t   edges,
	input  intra16_pkg::pred_block_t plane_blk,
	input  intra16_pkg::pred_mode_e  mode,
	input  logic [3:0]               block_idx,
	input  logic                     top_avail,
	input  logic                     left_avail,
	input  logic                     out_strobe,
	output intra16_pkg::pred_block_t pred
);

	localparam int SW = `SAMPLE_W;
	localparam int SUM_W = `SAMPLE_W + 6;   // Room for 32 samples and rounding

	logic [SUM_W-1:0] sum_top;
	logic [SUM_W-1:0] sum_left;
	logic [SUM_W-1:0] sum_all;
	logic [SW-1:0] dc_val;
	logic [3:0] col0;
	logic [3:0] row0;
	intra16_pkg::pred_block_t vert_blk;
	intra16_pkg::pred_block_t horz_blk;
	intra16_pkg::pred_block_t dc_blk;

	assign col0 = {block_idx[1:0], 2'b00};
	assign row0 = {block_idx[3:2], 2'b00};

	always_comb begin
		sum_top = '0;
		sum_left = '0;
		for (int i = 0; i < `EDGE_LEN; i++) begin
			sum_top = sum_top + SUM_W'(edges.top[i]);
			sum_left = sum_left + SUM_W'(edges.left[i]);
		end
	end

	assign sum_all = sum_top + sum_left + SUM_W'(`DC_RND_BOTH);

	// DC covers the whole macroblock, so block_idx plays no part here
	always_comb begin
		case ({top_avail, left_avail})
			2'b11: dc_val = SW'(sum_all >> 5);
			2'b10: dc_val = SW'((sum_top + SUM_W'(`DC_RND_ONE)) >> 4);
			2'b01: dc_val = SW'((sum_left + SUM_W'(`DC_RND_ONE)) >> 4);
			default: dc_val = SW'(`DC_DEFAULT);
		endcase
	end

	always_comb begin
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				vert_blk.px[4*y + x] = edges.top[col0 + 4'(x)];
				horz_blk.px[4*y + x] = edges.left[row0 + 4'(y)];
				dc_blk.px[4*y + x] = dc_val;
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			pred <= '0;
		end else if (out_strobe) begin
			case (mode)
				intra16_pkg::mode_vertical: pred <= vert_blk;
				intra16_pkg::mode_horizontal: pred <= horz_blk;
				intra16_pkg::mode_dc: pred <= dc_blk;
				intra16_pkg::mode_plane: pred <= plane_blk;   // Already clipped upstream
			endcase
		end
	end

endmodule

// ==== intra16_pred.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module intra16_pred (
	input  logic                     clk,
	input  logic                     reset_n,
	input  intra16_pkg::edge_op_e    edge_op,
	input  logic [`WORD_W-1:0]       edge_word,
	input  logic                     top_avail,
	input  logic                     left_avail,
	input  logic                     param_strobe,
	input  logic                     plane_strobe,
	input  logic                     out_strobe,
	input  logic [3:0]               block_idx,
	input  intra16_pkg::pred_mode_e  mode,
	output intra16_pkg::pred_block_t pred
);

	intra16_pkg::edge_set_t edges;
	intra16_pkg::plane_param_t params;
	intra16_pkg::pred_block_t plane_blk;

	intra16_edge_store u_edge_store (
		.clk(clk),
		.reset_n(reset_n),
		.edge_op(edge_op),
		.edge_word(edge_word),
		.edges(edges)
	);

	intra16_plane_param u_plane_param (
		.clk(clk),
		.reset_n(reset_n),
		.edges(edges),
		.param_strobe(param_strobe),
		.params(params)
	);

	intra16_plane_block u_plane_block (
		.clk(clk),
		.reset_n(reset_n),
		.params(params),
		.block_idx(block_idx),
		.plane_strobe(plane_strobe),
		.plane_blk(plane_blk)
	);

	intra16_block_out u_block_out (
		.clk(clk),
		.reset_n(reset_n),
		.edges(edges),
		.plane_blk(plane_blk),
		.mode(mode),
		.block_idx(block_idx),
		.top_avail(top_avail),
		.left_avail(left_avail),
		.out_strobe(out_strobe),
		.pred(pred)
	);

endmodule

// ==== intra16_properties.sv ====
`timescale 1ns/100ps

module intra16_properties (
	input logic                     clk,
	input logic                     reset_n,
	input logic                     out_strobe,
	input intra16_pkg::pred_mode_e  mode,
	input intra16_pkg::pred_block_t pred
);

	int fail_count = 0;   // Assertion failures so far

	reset_clears_pred: assert property (@(posedge clk) !reset_n |-> pred == '0)
		else begin
			fail_count++;
			$error("pred is not zero while reset_n is low");
		end

	// A new value in pred must come from the out_strobe one edge earlier
	pred_follows_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		!$stable(pred) |-> $past(out_strobe))
		else begin
			fail_count++;
			$error("pred changed without an out_strobe in the previous cycle");
		end

	mode_known: assert property (@(posedge clk) disable iff (!reset_n)
		out_strobe |-> !$isunknown(mode))
		else begin
			fail_count++;
			$error("mode is unknown while out_strobe is high");
		end

endmodule

bind intra16_pred intra16_properties u_properties (
	.clk(clk),
	.reset_n(reset_n),
	.out_strobe(out_strobe),
	.mode(mode),
	.pred(pred)
);

// ==== tb_intra16_pred.sv ====
`timescale 1ns/100ps
`include "intra16_macros.svh"

module tb_intra16_pred;

	typedef enum logic [1:0] {pat_random, pat_flat, pat_ramp_up, pat_ramp_down} pattern_e;

	// One row loads one edge set, then predicts num_blk blocks from first_blk on
	typedef struct packed {
		intra16_pkg::pred_mode_e mode;
		logic [3:0] first_blk;
		logic [4:0] num_blk;
		logic top_av;
		logic left_av;
		pattern_e pat;
	} case_t;

	localparam int NUM_CASES = 11;
	localparam int SW = `SAMPLE_W;
	localparam int PW = `PLANE_W;
	localparam logic [31:0] LFSR_MASK = 32'h80200003;

	case_t case_table [NUM_CASES] = '{
		'{intra16_pkg::mode_vertical, 4'd0, 5'd16, 1'b1, 1'b1, pat_random},
		'{intra16_pkg::mode_horizontal, 4'd0, 5'd16, 1'b1, 1'b1, pat_random},
		'{intra16_pkg::mode_dc, 4'd0, 5'd3, 1'b1, 1'b1, pat_random},
		'{intra16_pkg::mode_dc, 4'd5, 5'd3, 1'b1, 1'b0, pat_random},
		'{intra16_pkg::mode_dc, 4'd9, 5'd3, 1'b0, 1'b1, pat_random},
		'{intra16_pkg::mode_dc, 4'd13, 5'd3, 1'b0, 1'b0, pat_random},
		'{intra16_pkg::mode_plane, 4'd0, 5'd16, 1'b1, 1'b1, pat_random},
		'{intra16_pkg::mode_plane, 4'd0, 5'd16, 1'b1, 1'b1, pat_ramp_up},   // Clips at 255
		'{intra16_pkg::mode_plane, 4'd0, 5'd16, 1'b1, 1'b1, pat_ramp_down}, // Clips at 0
		'{intra16_pkg::mode_plane, 4'd4, 5'd4, 1'b1, 1'b1, pat_flat},
		'{intra16_pkg::mode_dc, 4'd0, 5'd2, 1'b1, 1'b1, pat_flat}
	};

	logic clk;
	logic reset_n;
	intra16_pkg::edge_op_e edge_op;
	logic [`WORD_W-1:0] edge_word;
	logic top_avail;
	logic left_avail;
	logic param_strobe;
	logic plane_strobe;
	logic out_strobe;
	logic [3:0] block_idx;
	intra16_pkg::pred_mode_e mode;
	intra16_pkg::pred_block_t pred;

	logic [31:0] lfsr_state = 32'h903890cf;
	logic [SW-1:0] top_s [`EDGE_LEN];
	logic [SW-1:0] left_s [`EDGE_LEN];
	logic [SW-1:0] corner_s;
	int block_errors = 0;
	int param_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	intra16_pred u_intra16_pred (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic int test_cycles();
		int n;
		n = 8 + 2 + 50;
		for (int r = 0; r < NUM_CASES; r++) begin
			n += 12 + 4 * int'(case_table[r].num_blk);   // Edge load, then 4 cycles a block
		end
		return n;
	endfunction

	function automatic logic [SW-1:0] random_byte();
		logic [SW-1:0] val;
		val = '0;
		for (int i = 0; i < SW; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_MASK : lfsr_state >> 1;
			val = {val[SW-2:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic int gradient_of(input bit use_left);
		int g;
		int far_v;
		int near_v;
		g = 0;
		for (int x = 0; x < 8; x++) begin
			far_v = use_left ? int'(left_s[8 + x]) : int'(top_s[8 + x]);
			if (x == 7) begin
				near_v = int'(corner_s);   // Sample -1 of either edge
			end else begin
				near_v = use_left ? int'(left_s[6 - x]) : int'(top_s[6 - x]);
			end
			g += (x + 1) * (far_v - near_v);
		end
		return g;
	endfunction

	function automatic void plane_terms(output int a, output int b, output int c);
		a = 16 * (int'(left_s[15]) + int'(top_s[15]));
		b = (5 * gradient_of(1'b0) + 32) >>> 6;
		c = (5 * gradient_of(1'b1) + 32) >>> 6;
	endfunction

	function automatic intra16_pkg::plane_param_t model_params();
		int a;
		int b;
		int c;
		intra16_pkg::plane_param_t p;
		plane_terms(a, b, c);
		p.a = PW'(a);
		p.b = PW'(b);
		p.c = PW'(c);
		return p;
	endfunction

	function automatic int clip_pix(input int v);
		return (v < 0) ? 0 : ((v > 255) ? 255 : v);
	endfunction

	function automatic intra16_pkg::pred_block_t expected_block(
		input intra16_pkg::pred_mode_e m,
		input logic [3:0] idx,
		input logic t_av,
		input logic l_av
	);
		intra16_pkg::pred_block_t blk;
		int col0;
		int row0;
		int sum_t;
		int sum_l;
		int dc;
		int a;
		int b;
		int c;
		col0 = 4 * (int'(idx) % 4);
		row0 = 4 * (int'(idx) / 4);
		sum_t = 0;
		sum_l = 0;
		for (int i = 0; i < `EDGE_LEN; i++) begin
			sum_t += int'(top_s[i]);
			sum_l += int'(left_s[i]);
		end
		if (t_av && l_av) begin
			dc = (sum_t + sum_l + 16) >> 5;
		end else if (t_av) begin
			dc = (sum_t + 8) >> 4;
		end else if (l_av) begin
			dc = (sum_l + 8) >> 4;
		end else begin
			dc = 128;
		end
		plane_terms(a, b, c);
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 4; x++) begin
				case (m)
					intra16_pkg::mode_vertical: blk.px[4*y + x] = top_s[col0 + x];
					intra16_pkg::mode_horizontal: blk.px[4*y + x] = left_s[row0 + y];
					intra16_pkg::mode_dc: blk.px[4*y + x] = SW'(dc);
					default: blk.px[4*y + x] =
						SW'(clip_pix((a + b*(col0 + x - 7) + c*(row0 + y - 7) + 16) >>> 5));
				endcase
			end
		end
		return blk;
	endfunction

	task automatic check_block(
		input string what,
		input intra16_pkg::pred_block_t got,
		input intra16_pkg::pred_block_t exp
	);
		if (got !== exp) begin
			block_errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_params(
		input intra16_pkg::plane_param_t got,
		input intra16_pkg::plane_param_t exp
	);
		if (got !== exp) begin
			param_errors++;
			$display("CHECK FAILED at %0t: params got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic make_edges(input pattern_e pat);
		for (int i = 0; i < `EDGE_LEN; i++) begin
			case (pat)
				pat_random: begin
					top_s[i] = random_byte();
					left_s[i] = random_byte();
				end
				pat_flat: begin
					top_s[i] = 8'd100;
					left_s[i] = 8'd100;
				end
				pat_ramp_up: begin
					top_s[i] = SW'(16 * i);
					left_s[i] = SW'(16 * i);
				end
				default: begin
					top_s[i] = SW'(240 - 16 * i);
					left_s[i] = SW'(240 - 16 * i);
				end
			endcase
		end
		case (pat)
			pat_random: corner_s = random_byte();
			pat_flat: corner_s = 8'd100;
			pat_ramp_up: corner_s = 8'd0;
			default: corner_s = 8'd255;
		endcase
	endtask

	task automatic load_edges();
		for (int w = 0; w < 4; w++) begin
			@(posedge clk);
			edge_op <= intra16_pkg::op_top;
			edge_word <= {top_s[4*w + 3], top_s[4*w + 2], top_s[4*w + 1], top_s[4*w]};
		end
		for (int w = 0; w < 4; w++) begin
			@(posedge clk);
			edge_op <= intra16_pkg::edge_op_e'(3'(int'(intra16_pkg::op_left0) + w));
			edge_word <= {left_s[4*w + 3], left_s[4*w + 2], left_s[4*w + 1], left_s[4*w]};
		end
		@(posedge clk);
		edge_op <= intra16_pkg::op_corner;
		edge_word <= {{(`WORD_W - SW){1'b0}}, corner_s};
		@(posedge clk);
		edge_op <= intra16_pkg::op_none;
		edge_word <= '0;
		param_strobe <= 1'b1;
		@(posedge clk);
		param_strobe <= 1'b0;
	endtask

	task automatic run_block(input case_t row, input int k);
		logic [3:0] idx;
		idx = row.first_blk + 4'(k);
		@(posedge clk);
		block_idx <= idx;
		mode <= row.mode;
		top_avail <= row.top_av;
		left_avail <= row.left_av;
		plane_strobe <= 1'b1;
		@(posedge clk);
		plane_strobe <= 1'b0;
		out_strobe <= 1'b1;
		@(posedge clk);
		out_strobe <= 1'b0;   // pred is registered at this edge
		@(negedge clk);
		check_block($sformatf("pred %s block %0d", row.mode.name(), idx), pred,
			expected_block(row.mode, idx, row.top_av, row.left_av));
	endtask

	initial begin
		edge_op = intra16_pkg::op_none;
		edge_word = '0;
		top_avail = 1'b0;
		left_avail = 1'b0;
		param_strobe = 1'b0;
		plane_strobe = 1'b0;
		out_strobe = 1'b0;
		block_idx = '0;
		mode = intra16_pkg::mode_vertical;
		reset_n = 1'b0;
		cycle_limit = test_cycles();
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_block("pred after reset", pred, '0);
		for (int r = 0; r < NUM_CASES; r++) begin
			make_edges(case_table[r].pat);
			load_edges();
			@(negedge clk);
			check_params(u_intra16_pred.params, model_params());
			for (int k = 0; k < int'(case_table[r].num_blk); k++) begin
				run_block(case_table[r], k);
			end
		end
		$display("Errors: %0d pred, %0d plane parameter, %0d assertion",
			block_errors, param_errors, u_intra16_pred.u_properties.fail_count);
		if (block_errors == 0 && param_errors == 0
			&& u_intra16_pred.u_properties.fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
intra16_pkg.sv
intra16_edge_store.sv
intra16_plane_param.sv
intra16_plane_block.sv
intra16_block_out.sv
intra16_pred.sv
intra16_properties.sv
tb_intra16_pred.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the verdict
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_intra16_pred \
	> build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_intra16_pred > sim.log 2>&1
cat sim.log
! grep -q ">>> FAIL" sim.log && grep -q ">>> PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
